// File: hdl/hpm_pkg.sv
// Performance monitor widths, CSR address map, event selector codes and counter types
package hpm_pkg;

  localparam int DATA_W     = 64;
  localparam int ADDR_W     = 12;
  localparam int NUM_EVENTS = 8;   // Event strobe inputs

  typedef logic [DATA_W-1:0] hpm_data_t;
  typedef logic [ADDR_W-1:0] hpm_addr_t;

  // Event selector codes, code k picks event bit k-1
  typedef enum logic [3:0] {
    EV_NONE        = 4'd0,
    EV_ICACHE_MISS = 4'd1,
    EV_DCACHE_MISS = 4'd2,
    EV_ITLB_MISS   = 4'd3,
    EV_DTLB_MISS   = 4'd4,
    EV_LOAD        = 4'd5,
    EV_STORE       = 4'd6,
    EV_MISPREDICT  = 4'd7,
    EV_EXCEPTION   = 4'd8
  } hpm_event_e;

  // ------------------------------------------------------------
  // CSR address map
  // ------------------------------------------------------------
  localparam hpm_addr_t CSR_COUNTER_BASE   = 12'hB03;  // Counter k at base + k
  localparam hpm_addr_t CSR_EVENT_BASE     = 12'h323;
  localparam hpm_addr_t CSR_THRESHOLD_BASE = 12'h7C0;
  localparam hpm_addr_t CSR_EBS_BASE_ADDR  = 12'h7D0;
  localparam hpm_addr_t CSR_EBS_MASK       = 12'h7D1;

  // Width of a counter index, at least one bit
  function automatic int cnt_idx_w(input int n);
    return (n > 1) ? $clog2(n) : 1;
  endfunction

endpackage

// File: hdl/ebs_pkg.sv
// Event-based sampling state encoding and store port constants
package ebs_pkg;

  // Sampler FSM
  typedef enum logic {
    EBS_IDLE     = 1'b0,  // Watching thresholds
    EBS_SAMPLING = 1'b1   // Walking the snapshot
  } ebs_state_e;

  // Address step per stored 64-bit word
  localparam int unsigned STORE_STRIDE = 8;

endpackage

// File: hdl/hpm_if.sv
// Interfaces hpm_cnt_wr_if and ebs_cfg_if with their modports
`timescale 1ns/1ps

// ------------------------------------------------------------
// Counter write path and event selectors, CSR file to bank
// ------------------------------------------------------------
interface hpm_cnt_wr_if
  import hpm_pkg::*;
#(
  parameter int NUM_COUNTERS = 4
) ();

  localparam int IDX_W = cnt_idx_w(NUM_COUNTERS);

  logic                          wr_valid;  // Single-cycle write strobe
  logic [IDX_W-1:0]              wr_idx;
  hpm_data_t                     wr_data;
  hpm_event_e [NUM_COUNTERS-1:0] sel;       // One selector per counter

  modport csr  (output wr_valid, output wr_idx, output wr_data, output sel);
  modport bank (input wr_valid, input wr_idx, input wr_data, input sel);

endinterface

// ------------------------------------------------------------
// Sampling configuration, CSR file to sampler
// ------------------------------------------------------------
interface ebs_cfg_if
  import hpm_pkg::*;
#(
  parameter int NUM_COUNTERS = 4
) ();

  hpm_data_t [NUM_COUNTERS-1:0] threshold;
  hpm_data_t                    base_addr;  // Store target base
  logic      [NUM_COUNTERS-1:0] mask;       // Counters to store
  logic                         base_wr;    // Pulses when base is written

  modport csr     (output threshold, output base_addr, output mask, output base_wr);
  modport sampler (input threshold, input base_addr, input mask, input base_wr);

endinterface

// File: hdl/hpm_csr_file.sv
// CSR file with address decode, read mux and selector, threshold, base and mask registers
`timescale 1ns/1ps

module hpm_csr_file
  import hpm_pkg::*;
#(
  parameter int NUM_COUNTERS = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  hpm_addr_t                    csr_addr_i,
  input  logic                         csr_we_i,
  input  hpm_data_t                    csr_wdata_i,
  output hpm_data_t                    csr_rdata_o,
  input  hpm_data_t [NUM_COUNTERS-1:0] counts_i,
  hpm_cnt_wr_if.csr                    cnt_wr,
  ebs_cfg_if.csr                       ebs_cfg
);

  localparam int IDX_W = cnt_idx_w(NUM_COUNTERS);

  hpm_event_e [NUM_COUNTERS-1:0] sel_q;
  hpm_data_t  [NUM_COUNTERS-1:0] thr_q;
  hpm_data_t                     base_q;
  logic       [NUM_COUNTERS-1:0] mask_q;

  logic [NUM_COUNTERS-1:0] cnt_hit;
  logic [NUM_COUNTERS-1:0] evt_hit;
  logic [NUM_COUNTERS-1:0] thr_hit;
  logic                    base_hit;
  logic                    mask_hit;
  logic [IDX_W-1:0]        cnt_idx;

  // ------------------------------------------------------------
  // Address decode
  // ------------------------------------------------------------
  always_comb begin
    cnt_idx = '0;
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      cnt_hit[i] = (csr_addr_i == CSR_COUNTER_BASE + hpm_addr_t'(i));
      evt_hit[i] = (csr_addr_i == CSR_EVENT_BASE + hpm_addr_t'(i));
      thr_hit[i] = (csr_addr_i == CSR_THRESHOLD_BASE + hpm_addr_t'(i));
      if (cnt_hit[i]) begin
        cnt_idx = IDX_W'(i);
      end
    end
  end

  assign base_hit = (csr_addr_i == CSR_EBS_BASE_ADDR);
  assign mask_hit = (csr_addr_i == CSR_EBS_MASK);

  // Read mux, unmapped reads as zero
  always_comb begin
    csr_rdata_o = '0;
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      if (cnt_hit[i]) begin
        csr_rdata_o = counts_i[i];
      end
      if (evt_hit[i]) begin
        csr_rdata_o = hpm_data_t'(sel_q[i]);
      end
      if (thr_hit[i]) begin
        csr_rdata_o = thr_q[i];
      end
    end
    if (base_hit) begin
      csr_rdata_o = base_q;
    end
    if (mask_hit) begin
      csr_rdata_o = hpm_data_t'(mask_q);
    end
  end

  // ------------------------------------------------------------
  // Configuration registers
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        sel_q[i] <= EV_NONE;
      end
      thr_q  <= '0;
      base_q <= '0;
      mask_q <= '0;
    end else if (csr_we_i) begin
      for (int i = 0; i < NUM_COUNTERS; i++) begin
        if (evt_hit[i]) begin
          sel_q[i] <= hpm_event_e'(csr_wdata_i[3:0]);  // Codes above 8 kept, count nothing
        end
        if (thr_hit[i]) begin
          thr_q[i] <= csr_wdata_i;
        end
      end
      if (base_hit) begin
        base_q <= csr_wdata_i;
      end
      if (mask_hit) begin
        mask_q <= csr_wdata_i[NUM_COUNTERS-1:0];
      end
    end
  end

  // Counter writes go to the bank as a strobe
  assign cnt_wr.wr_valid = csr_we_i && (|cnt_hit);
  assign cnt_wr.wr_idx   = cnt_idx;
  assign cnt_wr.wr_data  = csr_wdata_i;
  assign cnt_wr.sel      = sel_q;

  assign ebs_cfg.threshold = thr_q;
  assign ebs_cfg.base_addr = base_q;
  assign ebs_cfg.mask      = mask_q;
  assign ebs_cfg.base_wr   = csr_we_i && base_hit;

  a_we_addr_known: assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_we_i |-> !$isunknown(csr_addr_i));

endmodule

// File: hdl/hpm_counter_bank.sv
// Counter bank with per-counter event selection, increment rule and CSR write path
`timescale 1ns/1ps

module hpm_counter_bank
  import hpm_pkg::*;
#(
  parameter int NUM_COUNTERS = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  logic [NUM_EVENTS-1:0]        events_i,
  input  logic [NUM_COUNTERS-1:0]      inhibit_i,
  input  logic                         debug_mode_i,
  input  logic                         csr_we_i,
  hpm_cnt_wr_if.bank                   cnt_wr,
  output hpm_data_t [NUM_COUNTERS-1:0] counts_o
);

  localparam int IDX_W = cnt_idx_w(NUM_COUNTERS);
  localparam int EV_W  = $clog2(NUM_EVENTS);

  for (genvar g = 0; g < NUM_COUNTERS; g++) begin : g_cnt
    logic [3:0] code;
    logic [3:0] bit_idx;
    logic       ev_hit;
    logic       cnt_en;
    logic       wr_hit;
    hpm_data_t  cnt_q;

    // Event mux
    assign code    = cnt_wr.sel[g];
    assign bit_idx = code - 4'd1;
    assign ev_hit  = (code >= 4'(EV_ICACHE_MISS)) && (code <= 4'(EV_EXCEPTION))
                     && events_i[bit_idx[EV_W-1:0]];

    // No counting in debug mode or in any CSR write cycle
    assign cnt_en = ev_hit && !inhibit_i[g] && !debug_mode_i && !csr_we_i;
    assign wr_hit = cnt_wr.wr_valid && (cnt_wr.wr_idx == IDX_W'(g));

    always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
        cnt_q <= '0;
      end else if (wr_hit) begin
        cnt_q <= cnt_wr.wr_data;
      end else if (cnt_en) begin
        cnt_q <= cnt_q + 1'b1;
      end
    end

    assign counts_o[g] = cnt_q;
  end

endmodule

// File: hdl/ebs_sampler.sv
// Event-based sampler with threshold compare, snapshot and store sequencing FSM
`timescale 1ns/1ps

module ebs_sampler
  import hpm_pkg::*;
  import ebs_pkg::*;
#(
  parameter int NUM_COUNTERS = 4
) (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  input  hpm_data_t [NUM_COUNTERS-1:0] counts_i,
  ebs_cfg_if.sampler                   ebs_cfg,
  output logic                         store_req_o,
  output hpm_data_t                    store_addr_o,
  output hpm_data_t                    store_data_o,
  input  logic                         store_ack_i
);

  localparam int               IDX_W    = cnt_idx_w(NUM_COUNTERS);
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_COUNTERS - 1);

  ebs_state_e                   state_q;
  logic [IDX_W-1:0]             idx_q;
  hpm_data_t                    offset_q;    // Running store offset
  hpm_data_t                    base_q;      // Base held for one sample
  logic [NUM_COUNTERS-1:0]      mask_q;
  logic                         clr_pend_q;  // Base written while sampling
  hpm_data_t [NUM_COUNTERS-1:0] last_q;
  hpm_data_t [NUM_COUNTERS-1:0] snap_q;

  logic [NUM_COUNTERS-1:0] trig;
  logic                    step;

  // Threshold crossing relative to the last sample
  always_comb begin
    for (int i = 0; i < NUM_COUNTERS; i++) begin
      trig[i] = (ebs_cfg.threshold[i] != '0)
                && (counts_i[i] >= ebs_cfg.threshold[i] + last_q[i]);
    end
  end

  assign store_req_o  = (state_q == EBS_SAMPLING) && mask_q[idx_q];
  assign store_addr_o = base_q + offset_q;
  assign store_data_o = snap_q[idx_q];
  assign step         = !store_req_o || store_ack_i;  // Skip or acknowledged

  // ------------------------------------------------------------
  // Sampling FSM
  // ------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= EBS_IDLE;
      idx_q      <= '0;
      offset_q   <= '0;
      base_q     <= '0;
      mask_q     <= '0;
      clr_pend_q <= 1'b0;
      last_q     <= '0;
      snap_q     <= '0;
    end else begin
      case (state_q)
        EBS_IDLE: begin
          if (ebs_cfg.base_wr || clr_pend_q) begin
            offset_q   <= '0;
            clr_pend_q <= 1'b0;
          end
          if (|trig) begin
            state_q <= EBS_SAMPLING;
            idx_q   <= '0;
            snap_q  <= counts_i;
            base_q  <= ebs_cfg.base_addr;
            mask_q  <= ebs_cfg.mask;
            for (int i = 0; i < NUM_COUNTERS; i++) begin
              if (trig[i]) begin
                last_q[i] <= counts_i[i];
              end
            end
          end
        end
        EBS_SAMPLING: begin
          // Offset clear waits so the pending address stays put
          if (ebs_cfg.base_wr) begin
            clr_pend_q <= 1'b1;
          end
          if (store_req_o && store_ack_i) begin
            offset_q <= offset_q + hpm_data_t'(STORE_STRIDE);
          end
          if (step) begin
            if (idx_q == LAST_IDX) begin
              state_q <= EBS_IDLE;
              idx_q   <= '0;
            end else begin
              idx_q <= idx_q + 1'b1;
            end
          end
        end
      endcase
    end
  end

  a_req_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    store_req_o && !store_ack_i |=>
      store_req_o && $stable(store_addr_o) && $stable(store_data_o));

endmodule

// File: hdl/perf_counters_top.sv
// Performance monitor top level joining CSR file, counter bank and sampler
`timescale 1ns/1ps

module perf_counters_top
  import hpm_pkg::*;
#(
  parameter int NUM_COUNTERS = 4
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  // CSR port
  input  hpm_addr_t               csr_addr_i,
  input  logic                    csr_we_i,
  input  hpm_data_t               csr_wdata_i,
  output hpm_data_t               csr_rdata_o,
  // Event sources
  input  logic [NUM_EVENTS-1:0]   events_i,
  input  logic [NUM_COUNTERS-1:0] inhibit_i,
  input  logic                    debug_mode_i,
  // Sample store port
  output logic                    store_req_o,
  output hpm_data_t               store_addr_o,
  output hpm_data_t               store_data_o,
  input  logic                    store_ack_i
);

  hpm_data_t [NUM_COUNTERS-1:0] counts;

  hpm_cnt_wr_if #(.NUM_COUNTERS(NUM_COUNTERS)) u_cnt_wr_if ();
  ebs_cfg_if    #(.NUM_COUNTERS(NUM_COUNTERS)) u_ebs_cfg_if ();

  hpm_csr_file #(.NUM_COUNTERS(NUM_COUNTERS)) u_csr_file (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .csr_addr_i  (csr_addr_i),
    .csr_we_i    (csr_we_i),
    .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o),
    .counts_i    (counts),
    .cnt_wr      (u_cnt_wr_if.csr),
    .ebs_cfg     (u_ebs_cfg_if.csr)
  );

  hpm_counter_bank #(.NUM_COUNTERS(NUM_COUNTERS)) u_counter_bank (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .events_i     (events_i),
    .inhibit_i    (inhibit_i),
    .debug_mode_i (debug_mode_i),
    .csr_we_i     (csr_we_i),
    .cnt_wr       (u_cnt_wr_if.bank),
    .counts_o     (counts)
  );

  ebs_sampler #(.NUM_COUNTERS(NUM_COUNTERS)) u_ebs_sampler (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .counts_i     (counts),
    .ebs_cfg      (u_ebs_cfg_if.sampler),
    .store_req_o  (store_req_o),
    .store_addr_o (store_addr_o),
    .store_data_o (store_data_o),
    .store_ack_i  (store_ack_i)
  );

endmodule

// File: include/tb_helpers.svh
// Testbench helpers with Fibonacci LFSR step and CSR write and read tasks
`ifndef TB_HELPERS_SVH
`define TB_HELPERS_SVH

// Included inside the testbench module. Uses its clk, csr_addr, csr_we,
// csr_wdata and csr_rdata

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] fib_step(input logic [31:0] s);
  return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
endfunction

// One-cycle write strobe, inputs move 2 ns after the edge
task automatic csr_write(input logic [11:0] addr, input logic [63:0] data);
  @(posedge clk);
  #2;
  csr_addr  = addr;
  csr_wdata = data;
  csr_we    = 1'b1;
  @(posedge clk);
  #2;
  csr_we    = 1'b0;
endtask

// Read data is combinational, sampled shortly after the address settles
task automatic csr_read(input logic [11:0] addr, output logic [63:0] data);
  @(posedge clk);
  #2;
  csr_addr = addr;
  #1;
  data = csr_rdata;
endtask

`endif

// File: verification/tb_perf_counters.sv
// Testbench for perf_counters_top with clock, reset, directed tests, watchdog and summary
`timescale 1ns/1ps

module tb_perf_counters
  import hpm_pkg::*;
();

  localparam int NUM_CNT        = 4;
  localparam int TIMEOUT_CYCLES = 20000;  // Far above the ~800 cycles the tests take
  localparam int REQ_WAIT_MAX   = 50;     // Cycles allowed until a store request shows

  localparam hpm_data_t SAMPLE_THR = 64'd10;
  localparam hpm_data_t BASE_A     = 64'h0000_0000_8000_1000;
  localparam hpm_data_t BASE_B     = 64'h0000_0001_2000_0400;

  logic                  clk;
  logic                  rst_n;
  hpm_addr_t             csr_addr;
  logic                  csr_we;
  hpm_data_t             csr_wdata;
  hpm_data_t             csr_rdata;
  logic [NUM_EVENTS-1:0] events;
  logic [NUM_CNT-1:0]    inhibit;
  logic                  debug_mode;
  logic                  store_req;
  hpm_data_t             store_addr;
  hpm_data_t             store_data;
  logic                  store_ack;

  int          err_cnt;
  int          chk_cnt;
  int          cycle_cnt;
  logic [31:0] lfsr_q;
  hpm_data_t   exp_cnt [NUM_CNT];   // Reference counter values
  logic [3:0]  sel_code [NUM_CNT];
  hpm_addr_t   map_addr [$];        // CSR map with expected read values
  hpm_data_t   map_exp [$];
  hpm_data_t   exp_st_addr [$];     // Stores still to come
  hpm_data_t   exp_st_data [$];
  hpm_data_t   store_base;
  hpm_data_t   store_off;

  `include "tb_helpers.svh"

  perf_counters_top #(.NUM_COUNTERS(NUM_CNT)) u_perf_counters_top (
    .clk_i        (clk),
    .rst_ni       (rst_n),
    .csr_addr_i   (csr_addr),
    .csr_we_i     (csr_we),
    .csr_wdata_i  (csr_wdata),
    .csr_rdata_o  (csr_rdata),
    .events_i     (events),
    .inhibit_i    (inhibit),
    .debug_mode_i (debug_mode),
    .store_req_o  (store_req),
    .store_addr_o (store_addr),
    .store_data_o (store_data),
    .store_ack_i  (store_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // ------------------------------------------------------------
  // Reference model and common helpers
  // ------------------------------------------------------------
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = fib_step(lfsr_q);   // One step per bit
      r      = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // Code k watches event bit k-1, zero and codes above 8 watch nothing
  function automatic logic event_hit(input logic [3:0] code, input logic [NUM_EVENTS-1:0] ev);
    if (code == 4'd0 || code > 4'd8) begin
      return 1'b0;
    end
    return ev[code - 4'd1];
  endfunction

  // Increment rule for the cycle now driven
  function automatic void count_cycle();
    for (int i = 0; i < NUM_CNT; i++) begin
      if (event_hit(sel_code[i], events) && !inhibit[i] && !debug_mode && !csr_we) begin
        exp_cnt[i] = exp_cnt[i] + 64'd1;
      end
    end
  endfunction

  function automatic void expect_reg(input hpm_addr_t a, input hpm_data_t v);
    for (int k = 0; k < map_addr.size(); k++) begin
      if (map_addr[k] == a) begin
        map_exp[k] = v;
      end
    end
  endfunction

  task automatic value_error(input string what, input hpm_data_t got, input hpm_data_t exp);
    err_cnt++;
    $display("** Error at %0t: %s is %h, expected %h", $time, what, got, exp);
  endtask

  task automatic finish_test(input string name, input int errs_before);
    $display("Test %s: %s (%0d errors)", name,
             (err_cnt == errs_before) ? "ok" : "failed", err_cnt - errs_before);
  endtask

  task automatic check_map(input string stage);
    hpm_data_t rd;
    for (int k = 0; k < map_addr.size(); k++) begin
      csr_read(map_addr[k], rd);
      chk_cnt++;
      if (rd !== map_exp[k]) begin
        value_error($sformatf("%s, CSR %h", stage, map_addr[k]), rd, map_exp[k]);
      end
    end
  endtask

  task automatic set_selectors(input logic [3:0] c0, c1, c2, c3);
    logic [3:0] c [NUM_CNT];
    c = '{c0, c1, c2, c3};
    for (int i = 0; i < NUM_CNT; i++) begin
      csr_write(CSR_EVENT_BASE + hpm_addr_t'(i), {60'h0, c[i]});
      sel_code[i] = c[i];
    end
  endtask

  task automatic load_counters(input hpm_data_t v0, v1, v2, v3);
    hpm_data_t v [NUM_CNT];
    v = '{v0, v1, v2, v3};
    for (int i = 0; i < NUM_CNT; i++) begin
      csr_write(CSR_COUNTER_BASE + hpm_addr_t'(i), v[i]);
      exp_cnt[i] = v[i];
    end
  endtask

  task automatic compare_counters(input string stage);
    hpm_data_t rd;
    for (int i = 0; i < NUM_CNT; i++) begin
      csr_read(CSR_COUNTER_BASE + hpm_addr_t'(i), rd);
      chk_cnt++;
      if (rd !== exp_cnt[i]) begin
        value_error($sformatf("%s, counter %0d", stage, i), rd, exp_cnt[i]);
      end
    end
  endtask

  // Drive one event bit until the counter reaches target
  task automatic drive_event(input int idx, input int ev_bit, input hpm_data_t target);
    csr_addr       = CSR_COUNTER_BASE + hpm_addr_t'(idx);
    events         = '0;
    events[ev_bit] = 1'b1;
    while (exp_cnt[idx] != target) begin
      count_cycle();
      @(posedge clk);
      #2;
    end
    events = '0;
    chk_cnt++;
    if (csr_rdata !== target) begin
      value_error($sformatf("counter %0d at trigger", idx), csr_rdata, target);
    end
  endtask

  // Stores of one sample, masked counters in index order
  function automatic void expect_sample(input logic [NUM_CNT-1:0] mask);
    for (int i = 0; i < NUM_CNT; i++) begin
      if (mask[i]) begin
        exp_st_addr.push_back(store_base + store_off);
        exp_st_data.push_back(exp_cnt[i]);
        store_off = store_off + 64'd8;
      end
    end
  endfunction

  // Acknowledge each store after 0 to 5 cycles and watch it hold meanwhile
  task automatic serve_stores();
    hpm_data_t a;
    hpm_data_t d;
    int        wait_cnt;
    int        delay;
    while (exp_st_addr.size() > 0) begin
      wait_cnt = 0;
      while (!store_req && wait_cnt < REQ_WAIT_MAX) begin
        @(posedge clk);
        #2;
        wait_cnt++;
      end
      if (!store_req) begin
        err_cnt++;
        $display("No store request within %0d cycles at %0t, %0d stores missing",
                 REQ_WAIT_MAX, $time, exp_st_addr.size());
        exp_st_addr.delete();
        exp_st_data.delete();
      end else begin
        a = store_addr;
        d = store_data;
        chk_cnt += 2;
        if (a !== exp_st_addr[0]) value_error("store address", a, exp_st_addr[0]);
        if (d !== exp_st_data[0]) value_error("store data", d, exp_st_data[0]);
        delay = int'(rand_bits(3)) % 6;
        for (int k = 0; k < delay; k++) begin
          @(posedge clk);
          #2;
          chk_cnt++;
          if (!store_req || store_addr !== a || store_data !== d) begin
            err_cnt++;
            $display("Store request dropped or changed before its acknowledge at %0t", $time);
          end
        end
        store_ack = 1'b1;
        @(posedge clk);
        #2;
        store_ack = 1'b0;
        void'(exp_st_addr.pop_front());
        void'(exp_st_data.pop_front());
      end
    end
    // Remaining indices are skipped and the sampler goes idle
    repeat (NUM_CNT + 1) begin
      @(posedge clk);
      #2;
      chk_cnt++;
      if (store_req) begin
        err_cnt++;
        $display("Unexpected store request to %h at %0t", store_addr, $time);
      end
    end
  endtask

  // ------------------------------------------------------------
  // Directed tests
  // ------------------------------------------------------------
  task automatic test_reset_regs();
    int        errs_before;
    hpm_data_t wdata;
    errs_before = err_cnt;
    for (int i = 0; i < NUM_CNT; i++) begin
      map_addr.push_back(CSR_COUNTER_BASE + hpm_addr_t'(i));
      map_addr.push_back(CSR_EVENT_BASE + hpm_addr_t'(i));
      map_addr.push_back(CSR_THRESHOLD_BASE + hpm_addr_t'(i));
    end
    map_addr.push_back(CSR_EBS_BASE_ADDR);
    map_addr.push_back(CSR_EBS_MASK);
    map_addr.push_back(12'h7D2);  // Unmapped neighbours
    map_addr.push_back(12'h000);
    foreach (map_addr[k]) map_exp.push_back('0);
    check_map("reset value");

    for (int i = 0; i < NUM_CNT; i++) begin
      wdata = {rand_bits(32), 28'h0, 4'(i * 3 + 4)};  // Upper bits dropped on write
      csr_write(CSR_EVENT_BASE + hpm_addr_t'(i), wdata);
      expect_reg(CSR_EVENT_BASE + hpm_addr_t'(i), {60'h0, wdata[3:0]});
      wdata = {rand_bits(32), rand_bits(32)} | 64'h1;
      csr_write(CSR_THRESHOLD_BASE + hpm_addr_t'(i), wdata);
      expect_reg(CSR_THRESHOLD_BASE + hpm_addr_t'(i), wdata);
    end
    wdata = {rand_bits(32), 29'(rand_bits(29)), 3'b000};
    csr_write(CSR_EBS_BASE_ADDR, wdata);
    expect_reg(CSR_EBS_BASE_ADDR, wdata);
    csr_write(CSR_EBS_MASK, 64'hFFFF_FFFF_FFFF_FFF5);
    expect_reg(CSR_EBS_MASK, 64'h5);
    check_map("write readback");

    csr_write(12'h7D2, 64'hDEAD_BEEF_0000_0001);
    csr_write(CSR_COUNTER_BASE + hpm_addr_t'(NUM_CNT), 64'h55);
    csr_write(12'h000, '1);
    check_map("after unmapped writes");

    // Back to a quiet configuration
    for (int i = 0; i < NUM_CNT; i++) begin
      csr_write(CSR_THRESHOLD_BASE + hpm_addr_t'(i), '0);
    end
    csr_write(CSR_EBS_MASK, '0);
    set_selectors(4'd0, 4'd0, 4'd0, 4'd0);
    finish_test("1 reset and register access", errs_before);
  endtask

  task automatic test_event_count();
    int errs_before;
    errs_before = err_cnt;
    set_selectors(4'd5, 4'd1, 4'd7, 4'd3);
    load_counters(64'h0, 64'h1000, 64'h2000, 64'h3000);
    for (int c = 0; c < 200; c++) begin
      events = NUM_EVENTS'(rand_bits(NUM_EVENTS));
      count_cycle();
      @(posedge clk);
      #2;
    end
    events = '0;
    compare_counters("random events");

    // Codes above 8 stay still even with every event high
    set_selectors(4'd5, 4'd9, 4'd7, 4'd15);
    for (int c = 0; c < 40; c++) begin
      events = '1;
      count_cycle();
      @(posedge clk);
      #2;
    end
    events = '0;
    compare_counters("codes above 8");
    finish_test("2 event counting", errs_before);
  endtask

  task automatic test_inhibit_debug();
    int        errs_before;
    hpm_data_t wr_val;
    errs_before = err_cnt;
    wr_val      = 64'h0123_4567_89AB_CDEF;
    set_selectors(4'd1, 4'd2, 4'd3, 4'd4);
    load_counters(64'hFFFF_FFF0, 64'hFFFF_FFF8, 64'h7, 64'hFFFF_FFFF_FFFF_FF00);
    for (int c = 0; c < 200; c++) begin
      if (c == 101) begin
        chk_cnt++;
        if (csr_rdata !== wr_val) value_error("counter 2 after its write", csr_rdata, wr_val);
      end
      events     = NUM_EVENTS'(rand_bits(NUM_EVENTS));
      inhibit    = NUM_CNT'(rand_bits(NUM_CNT));
      debug_mode = (rand_bits(3) == 32'd0);
      csr_we     = 1'b0;
      if (c == 100) begin
        // Write cycle with every event high
        events     = '1;
        inhibit    = '0;
        debug_mode = 1'b0;
        csr_addr   = CSR_COUNTER_BASE + hpm_addr_t'(2);
        csr_wdata  = wr_val;
        csr_we     = 1'b1;
      end
      count_cycle();
      if (csr_we) exp_cnt[2] = wr_val;
      @(posedge clk);
      #2;
    end
    csr_we     = 1'b0;
    events     = '0;
    inhibit    = '0;
    debug_mode = 1'b0;
    compare_counters("inhibit and debug");
    finish_test("3 inhibit and debug", errs_before);
  endtask

  task automatic test_sampling();
    int errs_before;
    errs_before = err_cnt;
    set_selectors(4'd0, 4'd4, 4'd0, 4'd0);  // Only counter 1 counts, DTLB misses
    load_counters(64'hA0, 64'h0, 64'hC2, 64'hD3);
    csr_write(CSR_THRESHOLD_BASE + hpm_addr_t'(1), SAMPLE_THR);
    csr_write(CSR_EBS_BASE_ADDR, BASE_A);
    store_base = BASE_A;
    store_off  = '0;
    csr_write(CSR_EBS_MASK, 64'b1010);
    drive_event(1, 3, SAMPLE_THR);
    expect_sample(4'b1010);
    serve_stores();
    finish_test("4 sampling with back-pressure", errs_before);
  endtask

  task automatic test_resample();
    int errs_before;
    errs_before = err_cnt;
    csr_write(CSR_COUNTER_BASE + hpm_addr_t'(3), 64'hE5);
    exp_cnt[3] = 64'hE5;
    drive_event(1, 3, 2 * SAMPLE_THR);
    expect_sample(4'b1010);  // Offsets carry on at 16
    serve_stores();

    csr_write(CSR_EBS_BASE_ADDR, BASE_B);
    store_base = BASE_B;
    store_off  = '0;
    drive_event(1, 3, 3 * SAMPLE_THR);
    expect_sample(4'b1010);
    serve_stores();
    finish_test("5 repeated sampling and base rewrite", errs_before);
  endtask

  // ------------------------------------------------------------
  // Main sequence and watchdog
  // ------------------------------------------------------------
  initial begin
    rst_n      = 1'b0;
    csr_addr   = '0;
    csr_we     = 1'b0;
    csr_wdata  = '0;
    events     = '0;
    inhibit    = '0;
    debug_mode = 1'b0;
    store_ack  = 1'b0;
    lfsr_q     = 32'h38b9;
    err_cnt    = 0;
    chk_cnt    = 0;
    store_base = '0;
    store_off  = '0;
    for (int i = 0; i < NUM_CNT; i++) begin
      exp_cnt[i]  = '0;
      sel_code[i] = 4'd0;
    end
    repeat (16) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset_regs();
    test_event_count();
    test_inhibit_debug();
    test_sampling();
    test_resample();

    $display("Summary: %0d checks, %0d errors", chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

  initial begin
    for (cycle_cnt = 0; cycle_cnt < TIMEOUT_CYCLES; cycle_cnt++) begin
      @(posedge clk);
    end
    $display("Timeout after %0d cycles, the tests did not complete", TIMEOUT_CYCLES);
    $display("FAIL: see errors above");
    $finish;
  end

endmodule

// File: all.f
+incdir+include
hdl/hpm_pkg.sv
hdl/ebs_pkg.sv
hdl/hpm_if.sv
hdl/hpm_csr_file.sv
hdl/hpm_counter_bank.sv
hdl/ebs_sampler.sv
hdl/perf_counters_top.sv
verification/tb_perf_counters.sv

// File: Makefile
# Verilator build and run of the performance monitor testbench

VERILATOR ?= verilator
TOP       ?= tb_perf_counters
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG  ?= PASS: all tests

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# Fails unless the pass line appears in the simulation output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
